// File: include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and address word width
`define XLEN 32

// architectural integer registers
`define REG_COUNT 32

// bits needed to name one register
`define REG_IDX_W 5

// si12 field of the 2RI12 format
`define IMM12_W 12

// what is left of a word above si12
// used as the si20 width of lu12i.w
`define IMM20_W (`XLEN - `IMM12_W)

// 3R opcode field [31:15]
`define OP3R_W 17

`endif

// File: verilog/isa_pkg.sv
`default_nettype none

package isa_pkg;

    `include "core_settings.svh"

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // operations the core executes
    // addi.w shares ALU_ADD with add.w
    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_LUI
    } alu_op_e;

    // 3R format, opcode in inst[31:15]
    localparam logic [`OP3R_W-1:0] OP_ADD_W = 17'h00020;
    localparam logic [`OP3R_W-1:0] OP_SUB_W = 17'h00022;
    localparam logic [`OP3R_W-1:0] OP_SLT   = 17'h00024;
    localparam logic [`OP3R_W-1:0] OP_SLTU  = 17'h00025;
    localparam logic [`OP3R_W-1:0] OP_AND   = 17'h00029;
    localparam logic [`OP3R_W-1:0] OP_OR    = 17'h0002a;
    localparam logic [`OP3R_W-1:0] OP_XOR   = 17'h0002b;
    // 2RI12, opcode in inst[31:22]
    localparam logic [9:0] OP_ADDI_W = 10'h00a;
    // 1RI20, opcode in inst[31:25]
    localparam logic [6:0] OP_LU12I_W = 7'h0a;

    typedef struct packed {
        word_t   a;
        word_t   b;
        alu_op_e op;
    } operand_t;

endpackage

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import isa_pkg::*;

    // decode to execute
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        operand_t opnd;
        reg_idx_t rd;
        logic     rf_we;
    } idex_t;

    // execute to writeback
    // also what the debug port shows
    typedef struct packed {
        word_t    pc;
        word_t    inst;
        logic     rf_we;
        reg_idx_t rd;
        word_t    wdata;
    } commit_t;

    // one forwarding source seen by decode
    typedef struct packed {
        logic     valid;
        logic     rf_we;
        reg_idx_t rd;
        word_t    data;
    } bypass_t;

endpackage

`default_nettype wire

// File: verilog/pipe_stage_reg.sv
`timescale 1ns/10ps
`default_nettype none

module pipe_stage_reg import pipe_pkg::*; #(
    parameter type payload_t = idex_t
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     left_valid_i,
    output logic     left_ready_o,
    input  payload_t left_data_i,
    output logic     right_valid_o,
    input  logic     right_ready_i,
    output payload_t right_data_o
);

    logic     valid_q;
    payload_t data_q;

    // take a new item when empty or when the held one leaves
    assign left_ready_o = ~valid_q | right_ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
        end else if (left_ready_o) begin
            valid_q <= left_valid_i;
        end
    end

    // payload only moves on accept
    always_ff @(posedge clk) begin
        if (left_valid_i && left_ready_o) begin
            data_q <= left_data_i;
        end
    end

    assign right_valid_o = valid_q;
    assign right_data_o  = data_q;

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module decode_stage import isa_pkg::*; import pipe_pkg::*; (
    input  logic     inst_valid_i,
    output logic     inst_ready_o,
    input  word_t    inst_i,
    input  word_t    pc_i,
    output reg_idx_t rs1_idx_o,
    output reg_idx_t rs2_idx_o,
    input  word_t    rs1_data_i,
    input  word_t    rs2_data_i,
    input  bypass_t  ex_byp_i,
    input  bypass_t  wb_byp_i,
    output idex_t    idex_o,
    output logic     idex_valid_o,
    input  logic     idex_ready_i
);

    alu_op_e  alu_op;
    logic     imm_sel;
    word_t    imm;
    reg_idx_t rd;

    // newest producer wins, EX before WB before regfile
    function automatic word_t pick_operand(reg_idx_t idx, word_t rf_data,
                                           bypass_t ex, bypass_t wb);
        if (ex.valid && ex.rf_we && ex.rd == idx)
            return ex.data;
        if (wb.valid && wb.rf_we && wb.rd == idx)
            return wb.data;
        return rf_data;
    endfunction

    // no state here
    assign idex_valid_o = inst_valid_i;
    assign inst_ready_o = idex_ready_i;

    // rj and rk fields
    assign rs1_idx_o = inst_i[9:5];
    assign rs2_idx_o = inst_i[14:10];
    assign rd        = inst_i[4:0];

    always_comb begin
        alu_op  = ALU_NONE;
        imm_sel = 1'b0;
        imm     = '0;
        case (inst_i[31:15])
            OP_ADD_W: alu_op = ALU_ADD;
            OP_SUB_W: alu_op = ALU_SUB;
            OP_SLT:   alu_op = ALU_SLT;
            OP_SLTU:  alu_op = ALU_SLTU;
            OP_AND:   alu_op = ALU_AND;
            OP_OR:    alu_op = ALU_OR;
            OP_XOR:   alu_op = ALU_XOR;
            default:  alu_op = ALU_NONE;
        endcase
        // si12 sign-extended
        if (inst_i[31:22] == OP_ADDI_W) begin
            alu_op  = ALU_ADD;
            imm_sel = 1'b1;
            imm     = {{(`XLEN-`IMM12_W){inst_i[10+`IMM12_W-1]}}, inst_i[10 +: `IMM12_W]};
        end
        // si20 kept low, execute moves it up
        if (inst_i[31:25] == OP_LU12I_W) begin
            alu_op  = ALU_LUI;
            imm_sel = 1'b1;
            imm     = {{`IMM12_W{1'b0}}, inst_i[5 +: `IMM20_W]};
        end
    end

    always_comb begin
        idex_o.pc      = pc_i;
        idex_o.inst    = inst_i;
        idex_o.opnd.a  = pick_operand(rs1_idx_o, rs1_data_i, ex_byp_i, wb_byp_i);
        idex_o.opnd.b  = imm_sel ? imm
                                 : pick_operand(rs2_idx_o, rs2_data_i, ex_byp_i, wb_byp_i);
        idex_o.opnd.op = alu_op;
        idex_o.rd      = rd;
        // r0 writes dropped here once
        idex_o.rf_we   = (alu_op != ALU_NONE) && (rd != '0);
    end

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module execute_unit import isa_pkg::*; import pipe_pkg::*; (
    input  logic    idex_valid_i,
    input  idex_t   idex_i,
    output commit_t commit_o,
    output bypass_t ex_byp_o
);

    word_t a;
    word_t b;
    word_t result;

    assign a = idex_i.opnd.a;
    assign b = idex_i.opnd.b;

    always_comb begin
        case (idex_i.opnd.op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: result = {{(`XLEN-1){1'b0}}, a < b};
            // si20 into the upper bits
            ALU_LUI:  result = {b[`IMM20_W-1:0], {`IMM12_W{1'b0}}};
            default:  result = '0;
        endcase
    end

    assign commit_o = '{pc: idex_i.pc, inst: idex_i.inst, rf_we: idex_i.rf_we,
                        rd: idex_i.rd, wdata: result};

    // forwarding straight from the ALU
    assign ex_byp_o = '{valid: idex_valid_i, rf_we: idex_i.rf_we,
                        rd: idex_i.rd, data: result};

endmodule

`default_nettype wire

// File: verilog/regfile.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module regfile import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // operand ports for decode
    input  reg_idx_t rs1_idx_i,
    input  reg_idx_t rs2_idx_i,
    output word_t    rs1_data_o,
    output word_t    rs2_data_o,
    // debug read
    input  reg_idx_t dbg_idx_i,
    output word_t    dbg_data_o,
    // writeback
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  word_t    wr_data_i
);

    word_t regs [`REG_COUNT];

    // r0 filtered at decode, enable taken as is
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            regs <= '{default: '0};
        end else if (wr_en_i) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

    // r0 always reads zero
    assign rs1_data_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_data_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];
    assign dbg_data_o = (dbg_idx_i == '0) ? '0 : regs[dbg_idx_i];

endmodule

`default_nettype wire

// File: verilog/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top import isa_pkg::*; import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    // instruction stream
    input  logic     inst_valid_i,
    output logic     inst_ready_o,
    input  word_t    inst_i,
    input  word_t    pc_i,
    // holds writeback
    input  logic     break_point_i,
    // debug register read
    input  reg_idx_t reg_num_i,
    output word_t    rf_rdata_o,
    // commit port
    output logic     ws_valid_o,
    output commit_t  debug_wb_o
);

    // decode to ID/EX
    idex_t    dec_idex;
    logic     dec_valid;
    logic     dec_ready;
    // ID/EX to execute
    idex_t    ex_idex;
    logic     ex_valid;
    logic     ex_ready;
    commit_t  ex_commit;
    // EX/WB output
    commit_t  wb_commit;
    logic     wb_valid;
    logic     wb_ready;
    // forwarding back to decode
    bypass_t  ex_byp;
    bypass_t  wb_byp;
    // operand reads
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    decode_stage i_decode (
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_idx_o    (rs1_idx),
        .rs2_idx_o    (rs2_idx),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ex_byp_i     (ex_byp),
        .wb_byp_i     (wb_byp),
        .idex_o       (dec_idex),
        .idex_valid_o (dec_valid),
        .idex_ready_i (dec_ready)
    );

    pipe_stage_reg #(.payload_t(idex_t)) i_idex_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .left_valid_i (dec_valid),
        .left_ready_o (dec_ready),
        .left_data_i  (dec_idex),
        .right_valid_o(ex_valid),
        .right_ready_i(ex_ready),
        .right_data_o (ex_idex)
    );

    execute_unit i_execute (
        .idex_valid_i (ex_valid),
        .idex_i       (ex_idex),
        .commit_o     (ex_commit),
        .ex_byp_o     (ex_byp)
    );

    // writeback stalls while the break point is held
    assign wb_ready = ~break_point_i;

    pipe_stage_reg #(.payload_t(commit_t)) i_exwb_reg (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .left_valid_i (ex_valid),
        .left_ready_o (ex_ready),
        .left_data_i  (ex_commit),
        .right_valid_o(wb_valid),
        .right_ready_i(wb_ready),
        .right_data_o (wb_commit)
    );

    // retire happens on valid and ready together
    assign ws_valid_o = wb_valid & wb_ready;

    // a held WB item still forwards, regfile not yet written
    assign wb_byp = '{valid: wb_valid, rf_we: wb_commit.rf_we,
                      rd: wb_commit.rd, data: wb_commit.wdata};

    // single-bit write enable, only on retire
    assign debug_wb_o = '{pc: wb_commit.pc, inst: wb_commit.inst,
                          rf_we: wb_commit.rf_we & ws_valid_o,
                          rd: wb_commit.rd, wdata: wb_commit.wdata};

    regfile i_regfile (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_idx_i  (rs1_idx),
        .rs2_idx_i  (rs2_idx),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .dbg_idx_i  (reg_num_i),
        .dbg_data_o (rf_rdata_o),
        .wr_en_i    (debug_wb_o.rf_we),
        .wr_idx_i   (wb_commit.rd),
        .wr_data_i  (wb_commit.wdata)
    );

endmodule

`default_nettype wire

// File: verification/core_top_properties.sv
`timescale 1ns/10ps
`default_nettype none

module core_top_properties import pipe_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    input  logic    break_point_i,
    input  logic    inst_ready_o,
    input  logic    ws_valid_o,
    input  commit_t debug_wb_o
);

    // failed properties so far
    int unsigned fail_count = 0;

    // hold gates retire directly
    assert property (@(posedge clk) disable iff (!rst_n_i) break_point_i |-> !ws_valid_o)
        else begin
            $error("ws_valid_o high while break_point_i held");
            fail_count++;
        end

    assert property (@(posedge clk) !rst_n_i |-> !ws_valid_o)
        else begin
            $error("ws_valid_o high during reset");
            fail_count++;
        end

    // r0 writes dropped at decode
    assert property (@(posedge clk) disable iff (!rst_n_i)
                     debug_wb_o.rf_we |-> debug_wb_o.rd != '0)
        else begin
            $error("debug write enable with destination r0");
            fail_count++;
        end

    // both stages empty out of reset
    assert property (@(posedge clk) $rose(rst_n_i) |-> inst_ready_o)
        else begin
            $error("inst_ready_o low in first cycle after reset");
            fail_count++;
        end

endmodule

bind core_top core_top_properties i_props (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .break_point_i(break_point_i),
    .inst_ready_o (inst_ready_o),
    .ws_valid_o   (ws_valid_o),
    .debug_wb_o   (debug_wb_o)
);

`default_nettype wire

// File: verification/core_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module core_top_tb import isa_pkg::*, pipe_pkg::*; ();

    localparam logic [31:0] SEED         = 32'h1fc50a66;
    localparam int          RESET_CYCLES = 16;
    localparam int          RUN_TIMEOUT  = 2000;
    localparam int          HOLD_CYCLES  = 8;
    localparam int          TABLE_MAX    = 256;
    localparam int          RANDOM_OPS   = 200;
    // hold patterns for a table run
    localparam int HOLD_NONE   = 0;
    localparam int HOLD_RANDOM = 1;
    localparam int HOLD_BLOCK  = 2;
    // opcode fields, LoongArch32 base encodings
    localparam logic [16:0] OPC_ADD   = 17'h00020;
    localparam logic [16:0] OPC_SUB   = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_SLTU  = 17'h00025;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002a;
    localparam logic [16:0] OPC_XOR   = 17'h0002b;
    localparam logic [9:0]  OPC_ADDI  = 10'h00a;
    localparam logic [6:0]  OPC_LU12I = 7'h0a;
    // mul.w and andi, both outside the core's set
    localparam logic [16:0] OPC_MUL   = 17'h00038;
    localparam logic [9:0]  OPC_ANDI  = 10'h00d;

    // one stimulus row with its expected commit
    typedef struct packed {
        word_t    inst;
        word_t    pc;
        logic     rf_we;
        reg_idx_t rd;
        word_t    data;
    } entry_t;

    logic     clk;
    logic     rst_n_i;
    logic     inst_valid_i;
    logic     inst_ready_o;
    word_t    inst_i;
    word_t    pc_i;
    logic     break_point_i;
    reg_idx_t reg_num_i;
    word_t    rf_rdata_o;
    logic     ws_valid_o;
    commit_t  debug_wb_o;

    word_t       model_regs [`REG_COUNT];
    entry_t      table_q [TABLE_MAX];
    int          table_len;
    word_t       next_pc;
    logic [31:0] lfsr_q;
    int          cycle_cnt;
    commit_t     exp_q [$];
    int          acc_q [$];

    core_top i_dut (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_ready_o (inst_ready_o),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .break_point_i(break_point_i),
        .reg_num_i    (reg_num_i),
        .rf_rdata_o   (rf_rdata_o),
        .ws_valid_o   (ws_valid_o),
        .debug_wb_o   (debug_wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t take_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    task automatic stop_run(string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_commit(commit_t got, commit_t exp);
        commit_t seen;
        seen = got;
        // write data carries no meaning without a write
        if (!exp.rf_we)
            seen.wdata = exp.wdata;
        if (seen !== exp)
            stop_run($sformatf("CHECK FAILED t=%0t debug_wb_o got %h expected %h",
                               $time, got, exp));
    endtask

    always @(negedge clk) begin
        if (i_dut.i_props.fail_count != 0)
            stop_run("a property bound to core_top failed");
    end

    function automatic logic [16:0] op3r_code(alu_op_e op);
        case (op)
            ALU_SUB:  return OPC_SUB;
            ALU_AND:  return OPC_AND;
            ALU_OR:   return OPC_OR;
            ALU_XOR:  return OPC_XOR;
            ALU_SLT:  return OPC_SLT;
            ALU_SLTU: return OPC_SLTU;
            default:  return OPC_ADD;
        endcase
    endfunction

    // result rules of the 3R operations
    function automatic word_t alu_model(alu_op_e op, word_t a, word_t b);
        case (op)
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            default:  return a + b;
        endcase
    endfunction

    // model updated in program order as rows are built
    task automatic add_entry(word_t inst, logic writes, reg_idx_t rd, word_t data);
        entry_t e;
        if (table_len >= TABLE_MAX)
            stop_run("stimulus table overflow");
        e = '{inst: inst, pc: next_pc, rf_we: writes && (rd != '0), rd: rd, data: data};
        if (e.rf_we)
            model_regs[rd] = data;
        table_q[table_len] = e;
        table_len++;
        next_pc += 32'd4;
    endtask

    task automatic add_3r(alu_op_e op, reg_idx_t rd, reg_idx_t rj, reg_idx_t rk);
        add_entry({op3r_code(op), rk, rj, rd}, 1'b1, rd,
                  alu_model(op, model_regs[rj], model_regs[rk]));
    endtask

    task automatic add_addi(reg_idx_t rd, reg_idx_t rj, logic [11:0] si12);
        add_entry({OPC_ADDI, si12, rj, rd}, 1'b1, rd, model_regs[rj] + {{20{si12[11]}}, si12});
    endtask

    task automatic add_lu12i(reg_idx_t rd, logic [19:0] si20);
        add_entry({OPC_LU12I, si20, rd}, 1'b1, rd, {si20, 12'h000});
    endtask

    task automatic add_unknown(word_t inst);
        add_entry(inst, 1'b0, inst[4:0], '0);
    endtask

    task automatic add_random_op();
        alu_op_e  ops [7];
        word_t    kind;
        reg_idx_t rd;
        reg_idx_t rj;
        reg_idx_t rk;
        ops  = '{ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU};
        kind = take_bits(4);
        // r0 to r7 only, so hazards are frequent
        rd   = reg_idx_t'(take_bits(3));
        rj   = reg_idx_t'(take_bits(3));
        rk   = reg_idx_t'(take_bits(3));
        if (kind < 7)
            add_3r(ops[kind], rd, rj, rk);
        else if (kind < 11)
            add_addi(rd, rj, 12'(take_bits(12)));
        else if (kind < 13)
            add_lu12i(rd, 20'(take_bits(20)));
        else if (kind < 14)
            add_unknown({OPC_MUL, rk, rj, rd});
        else
            add_3r(ops[kind - 14], rd, rj, rk);
    endtask

    // drive on falling edge, sample 1 ns later while outputs are stable
    task automatic run_table(int hold_mode);
        int   idx;
        int   cycles;
        logic ready_low_seen;
        idx            = 0;
        cycles         = 0;
        ready_low_seen = 1'b0;
        while (idx < table_len || exp_q.size() > 0) begin
            @(negedge clk);
            case (hold_mode)
                HOLD_NONE:   break_point_i = 1'b0;
                HOLD_RANDOM: break_point_i = (take_bits(2) == '0);
                default:     break_point_i = (cycles < HOLD_CYCLES);
            endcase
            inst_valid_i = (idx < table_len);
            if (idx < table_len) begin
                inst_i = table_q[idx].inst;
                pc_i   = table_q[idx].pc;
            end
            #1;
            if (break_point_i && ws_valid_o)
                stop_run("commit seen while break_point_i was held");
            if (ws_valid_o) begin
                if (exp_q.size() == 0)
                    stop_run("commit seen with no instruction outstanding");
                if (hold_mode == HOLD_NONE)
                    check_word("commit latency", word_t'(cycle_cnt - acc_q[0]), 32'd2);
                check_commit(debug_wb_o, exp_q.pop_front());
                void'(acc_q.pop_front());
            end
            if (!inst_ready_o)
                ready_low_seen = 1'b1;
            if (hold_mode == HOLD_BLOCK && cycles == 3 && !ready_low_seen)
                stop_run("inst_ready_o did not fall within three cycles of the hold");
            if (inst_valid_i && inst_ready_o) begin
                exp_q.push_back('{pc: table_q[idx].pc, inst: table_q[idx].inst,
                                  rf_we: table_q[idx].rf_we, rd: table_q[idx].rd,
                                  wdata: table_q[idx].data});
                acc_q.push_back(cycle_cnt);
                idx++;
            end
            cycles++;
            cycle_cnt++;
            if (cycles > RUN_TIMEOUT)
                stop_run("timeout waiting for the pipeline to accept and retire");
        end
        @(negedge clk);
        inst_valid_i  = 1'b0;
        break_point_i = 1'b0;
        table_len     = 0;
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < `REG_COUNT; i++) begin
            @(negedge clk);
            reg_num_i = reg_idx_t'(i);
            #1;
            check_word($sformatf("rf_rdata_o[r%0d]", i), rf_rdata_o, model_regs[i]);
        end
    endtask

    initial begin
        rst_n_i       = 1'b0;
        inst_valid_i  = 1'b0;
        inst_i        = '0;
        pc_i          = '0;
        break_point_i = 1'b0;
        reg_num_i     = '0;
        lfsr_q        = SEED;
        table_len     = 0;
        next_pc       = 32'h1c000000;
        cycle_cnt     = 0;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
            check_word("ws_valid_o", word_t'(ws_valid_o), '0);
        end
        rst_n_i = 1'b1;
        #1;
        check_word("ws_valid_o", word_t'(ws_valid_o), '0);
        check_word("inst_ready_o", word_t'(inst_ready_o), 32'd1);
        check_all_regs();

        // operand setup, then every operation kind
        add_lu12i(5'd1, 20'h12345);
        add_lu12i(5'd2, 20'hfedcb);
        add_addi(5'd3, 5'd0, 12'h7ff);
        add_addi(5'd4, 5'd0, 12'h800);
        add_3r(ALU_ADD, 5'd5, 5'd1, 5'd2);
        add_3r(ALU_SUB, 5'd6, 5'd1, 5'd2);
        add_3r(ALU_AND, 5'd7, 5'd1, 5'd2);
        add_3r(ALU_OR, 5'd8, 5'd3, 5'd4);
        add_3r(ALU_XOR, 5'd9, 5'd1, 5'd4);
        add_3r(ALU_SLT, 5'd10, 5'd2, 5'd1);
        add_3r(ALU_SLTU, 5'd11, 5'd2, 5'd1);
        add_3r(ALU_SLT, 5'd12, 5'd4, 5'd3);
        add_3r(ALU_SLTU, 5'd13, 5'd4, 5'd3);
        run_table(HOLD_NONE);
        check_all_regs();

        // back to back chain, EX and WB forwarding
        add_lu12i(5'd14, 20'h0abcd);
        add_addi(5'd15, 5'd14, 12'hf01);
        add_3r(ALU_ADD, 5'd16, 5'd15, 5'd14);
        add_3r(ALU_SUB, 5'd17, 5'd16, 5'd15);
        add_3r(ALU_XOR, 5'd18, 5'd17, 5'd16);
        add_3r(ALU_SLTU, 5'd19, 5'd18, 5'd17);
        add_3r(ALU_OR, 5'd20, 5'd19, 5'd18);
        add_3r(ALU_AND, 5'd20, 5'd20, 5'd17);
        add_addi(5'd20, 5'd20, 12'h001);
        run_table(HOLD_NONE);

        // r0 targets and words outside the set
        add_3r(ALU_ADD, 5'd0, 5'd1, 5'd2);
        add_addi(5'd0, 5'd1, 12'h123);
        add_lu12i(5'd0, 20'hfffff);
        add_unknown({OPC_MUL, 5'd2, 5'd1, 5'd21});
        add_unknown({OPC_ANDI, 12'hfff, 5'd1, 5'd22});
        add_addi(5'd21, 5'd0, 12'h055);
        run_table(HOLD_NONE);
        check_all_regs();

        // long hold from the first cycle of a stream
        add_addi(5'd23, 5'd21, 12'h001);
        add_3r(ALU_ADD, 5'd24, 5'd23, 5'd21);
        add_3r(ALU_SUB, 5'd25, 5'd24, 5'd23);
        add_addi(5'd26, 5'd25, 12'hffe);
        add_3r(ALU_XOR, 5'd27, 5'd26, 5'd24);
        add_lu12i(5'd28, 20'h80000);
        run_table(HOLD_BLOCK);
        check_all_regs();

        for (int i = 0; i < RANDOM_OPS; i++)
            add_random_op();
        run_table(HOLD_RANDOM);
        check_all_regs();

        if (i_dut.i_props.fail_count != 0) begin
            stop_run("a property bound to core_top failed");
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/pipe_stage_reg.sv
verilog/decode_stage.sv
verilog/execute_unit.sv
verilog/regfile.sv
verilog/core_top.sv
verification/core_top_properties.sv
verification/core_top_tb.sv

// File: Bender.yml
package:
  name: core_top

sources:
  - include_dirs:
      - include
    files:
      - verilog/isa_pkg.sv
      - verilog/pipe_pkg.sv
      - verilog/pipe_stage_reg.sv
      - verilog/decode_stage.sv
      - verilog/execute_unit.sv
      - verilog/regfile.sv
      - verilog/core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/core_top_properties.sv
      - verification/core_top_tb.sv
